//--- hw/l2Cache_config.svh
/*
 * Build-time sizes for the L2 tile cache.
 * Included by the package and by every module that sizes a port with them.
 */
`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

// line index width, 64 lines
`define L2_INDEX_BITS 6

// one tile per line
`define L2_TILE_BITS 128

// ring byte address
`define L2_ADDR_BITS 32

// tile address, byte offset bits dropped
`define L2_TAG_BITS (`L2_ADDR_BITS - 4)

// flush rover, 0 is the all-invalid generation
`define L2_GEN_BITS 4

// ring cycles from ringIn to ringOut
`define L2_RING_LAT 3

`endif

//--- hw/l2CachePkg.sv
/*
 * Shared types for the L2 tile cache: ring and DDR encodings, array entries,
 * miss handoff, plus the index hash and message decode helpers.
 */
`include "l2Cache_config.svh"

package l2CachePkg;

	typedef enum logic [7:0] {
		RING_IDLE  = 8'h00,
		RING_LDX   = 8'h93,
		RING_STX   = 8'h97,
		RING_OKLD  = 8'h53,
		RING_OKST  = 8'h57,
		RING_FLUSH = 8'h9F
	} ringOp_t;

	typedef enum logic [4:0] {
		DDR_READY   = 5'h00,
		DDR_RD_TILE = 5'h11,
		DDR_WR_TILE = 5'h12
	} ddrOp_t;

	typedef enum logic [1:0] {
		OK_READY = 2'b00,
		OK_OK    = 2'b01,
		OK_HOLD  = 2'b10
	} ddrOk_t;

	typedef enum logic [2:0] {
		MISS_IDLE,
		MISS_WR_REQ,
		MISS_WR_END,
		MISS_RD_REQ,
		MISS_FILL
	} missState_t;

	typedef struct packed {
		logic [15:0] seq;
		ringOp_t opcode;
		logic [`L2_ADDR_BITS-1:0] addr;
		logic [`L2_TILE_BITS-1:0] data;
	} ringMsg_t;

	typedef struct packed {
		logic [`L2_TAG_BITS-1:0] tag;
		logic dirty;
		logic [`L2_GEN_BITS-1:0] gen;
		logic [`L2_TILE_BITS-1:0] tile;
	} lineInfo_t;

	typedef struct packed {
		logic en;
		logic [`L2_INDEX_BITS-1:0] index;
		lineInfo_t line;
	} lineWrite_t;

	typedef struct packed {
		logic [`L2_INDEX_BITS-1:0] index;
		logic [`L2_TAG_BITS-1:0] tag;
		lineInfo_t victim;
	} missReq_t;

	typedef struct packed {
		ddrOp_t opcode;
		logic [`L2_ADDR_BITS-1:0] addr;
		logic [`L2_TILE_BITS-1:0] data;
	} ddrReq_t;

	typedef struct packed {
		ddrOk_t ok;
		logic [`L2_TILE_BITS-1:0] data;
	} ddrRsp_t;

	// fold the next index-sized slice into the low bits
	function automatic logic [`L2_INDEX_BITS-1:0] lineIndex(input logic [`L2_TAG_BITS-1:0] tag);
		return tag[`L2_INDEX_BITS-1:0] ^ tag[2*`L2_INDEX_BITS-1:`L2_INDEX_BITS];
	endfunction

	function automatic logic isRamAddr(input logic [`L2_ADDR_BITS-1:0] addr);
		return (addr[31:30] == 2'b00) && (addr[29:24] != 6'h00);
	endfunction

	function automatic logic isFlushMsg(input ringMsg_t msg);
		return (msg.opcode == RING_FLUSH) && (msg.addr[31:28] == 4'hF) &&
			(msg.addr[3:0] == 4'hE);
	endfunction

endpackage

//--- hw/l2FlushRover.sv
/*
 * Line generation counter. A flush moves it on by one, which makes
 * every line stamped earlier read as absent. Generation 0 is left on its own.
 */
`include "l2Cache_config.svh"

module l2FlushRover (
	input  logic clock,
	input  logic reset,
	input  logic flushSeen,
	output logic [`L2_GEN_BITS-1:0] curGen
);

	// one cycle between the request to move and the move itself
	logic advance;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			advance <= 1'b0;
			curGen <= '0;
		end
		else
		begin
			// generation 0 asks for its own advance, once
			advance <= flushSeen || ((curGen == '0) && !advance);
			if (advance)
			begin
				curGen <= curGen + 1'b1;
			end
		end
	end

endmodule

//--- hw/l2TagStore.sv
/*
 * Line arrays of the cache: tag, flags (dirty and generation) and tile.
 * One registered read port, one write port shared by fills and store hits.
 * Fills win when both write in the same cycle.
 */
`include "l2Cache_config.svh"

module l2TagStore (
	input  logic clock,
	input  logic [`L2_INDEX_BITS-1:0] readIndex,
	output l2CachePkg::lineInfo_t readLine,
	input  l2CachePkg::lineWrite_t storeWrite,
	input  l2CachePkg::lineWrite_t fillWrite
);
	import l2CachePkg::*;

	localparam int lineCount = 1 << `L2_INDEX_BITS;

	logic [`L2_TAG_BITS-1:0] tagArr [lineCount];
	logic [`L2_GEN_BITS:0] flagArr [lineCount];
	logic [`L2_TILE_BITS-1:0] tileArr [lineCount];

	lineWrite_t lineWr;

	// fill has priority, the pipe turns a colliding store into a skip
	always_comb
	begin
		if (fillWrite.en)
		begin
			lineWr = fillWrite;
		end
		else
		begin
			lineWr = storeWrite;
		end
	end

	always_ff @(posedge clock)
	begin
		if (lineWr.en)
		begin
			tagArr[lineWr.index] <= lineWr.line.tag;
			flagArr[lineWr.index] <= {lineWr.line.dirty, lineWr.line.gen};
			tileArr[lineWr.index] <= lineWr.line.tile;
		end
	end

	// read sees the old entry when the same index is written at this edge
	always_ff @(posedge clock)
	begin
		readLine.tag <= tagArr[readIndex];
		{readLine.dirty, readLine.gen} <= flagArr[readIndex];
		readLine.tile <= tileArr[readIndex];
	end

endmodule

//--- hw/l2MissFsm.sv
/*
 * Miss engine. Takes one miss at a time from the ring pipe, writes a dirty
 * victim back over DDR, reads the new tile and fills the line as clean.
 */
`include "l2Cache_config.svh"

module l2MissFsm (
	input  logic clock,
	input  logic reset,
	input  logic missValid,
	output logic missReady,
	input  l2CachePkg::missReq_t missReq,
	input  logic [`L2_GEN_BITS-1:0] curGen,
	output l2CachePkg::lineWrite_t fillWrite,
	output l2CachePkg::ddrReq_t ddrReq,
	input  l2CachePkg::ddrRsp_t ddrRsp
);
	import l2CachePkg::*;

	missState_t state;
	logic [`L2_INDEX_BITS-1:0] reqIndex;
	logic [`L2_TAG_BITS-1:0] reqTag;
	lineInfo_t victim;
	logic [`L2_TILE_BITS-1:0] fillTile;
	logic ddrIdle;
	logic ddrDone;

	assign missReady = (state == MISS_IDLE);

	// bus free for a new request, or current request acknowledged
	assign ddrIdle = (ddrReq.opcode == DDR_READY) && (ddrRsp.ok == OK_READY);
	assign ddrDone = (ddrReq.opcode != DDR_READY) && (ddrRsp.ok == OK_OK);

	always_comb
	begin
		fillWrite.en = (state == MISS_FILL);
		fillWrite.index = reqIndex;
		fillWrite.line = '{tag: reqTag, dirty: 1'b0, gen: curGen, tile: fillTile};
	end

	always_ff @(posedge clock)
	begin
		if (missValid && missReady)
		begin
			reqIndex <= missReq.index;
			reqTag <= missReq.tag;
			victim <= missReq.victim;
		end
		if ((state == MISS_RD_REQ) && ddrDone)
		begin
			fillTile <= ddrRsp.data;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= MISS_IDLE;
			ddrReq <= '0;
		end
		else
		begin
			case (state)
				MISS_IDLE:
				begin
					if (missValid && missReady)
					begin
						state <= missReq.victim.dirty ? MISS_WR_REQ : MISS_RD_REQ;
					end
				end
				MISS_WR_REQ:
				begin
					if (ddrIdle)
					begin
						ddrReq.opcode <= DDR_WR_TILE;
						ddrReq.addr <= {victim.tag, 4'h0};
						ddrReq.data <= victim.tile;
					end
					else if (ddrDone)
					begin
						ddrReq.opcode <= DDR_READY;
						state <= MISS_WR_END;
					end
				end
				// write finished, wait until DDR is back to ready
				MISS_WR_END:
				begin
					if (ddrRsp.ok == OK_READY)
					begin
						state <= MISS_RD_REQ;
					end
				end
				MISS_RD_REQ:
				begin
					if (ddrIdle)
					begin
						ddrReq.opcode <= DDR_RD_TILE;
						ddrReq.addr <= {reqTag, 4'h0};
						ddrReq.data <= '0;
					end
					else if (ddrDone)
					begin
						ddrReq.opcode <= DDR_READY;
						state <= MISS_FILL;
					end
				end
				MISS_FILL:
				begin
					state <= MISS_IDLE;
				end
				default:
				begin
					state <= MISS_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/l2RingPipe.sv
/*
 * Three-stage ring pipeline. Stage 1 captures the message and reads the line,
 * stage 2 decides hit, store or miss, stage 3 drives the ring out.
 * Served requests turn into OKLD/OKST, everything else passes untouched.
 */
`include "l2Cache_config.svh"

module l2RingPipe (
	input  logic clock,
	input  logic reset,
	input  l2CachePkg::ringMsg_t ringIn,
	output l2CachePkg::ringMsg_t ringOut,
	output logic [`L2_INDEX_BITS-1:0] readIndex,
	input  l2CachePkg::lineInfo_t readLine,
	input  logic [`L2_GEN_BITS-1:0] curGen,
	output l2CachePkg::lineWrite_t storeWrite,
	input  l2CachePkg::lineWrite_t fillWrite,
	output logic missValid,
	input  logic missReady,
	output l2CachePkg::missReq_t missReq,
	output logic flushSeen
);
	import l2CachePkg::*;

	ringMsg_t s1Msg;
	ringMsg_t s2Msg;
	ringMsg_t served;
	logic [`L2_INDEX_BITS-1:0] s1Index;
	logic [`L2_INDEX_BITS-1:0] s2Index;
	logic [`L2_INDEX_BITS-1:0] prevWrIndex;
	logic [`L2_INDEX_BITS-1:0] pendIndex;
	logic [`L2_TAG_BITS-1:0] reqTag;
	logic prevWrEn;
	logic isLoad;
	logic isStore;
	logic isRamReq;
	logic tagHit;
	logic hit;
	logic skip;

	always_ff @(posedge clock)
	begin
		s1Msg <= ringIn;
		s1Index <= lineIndex(ringIn.addr[`L2_ADDR_BITS-1:4]);
		s2Msg <= s1Msg;
		s2Index <= s1Index;
		if (reset)
		begin
			s1Msg.opcode <= RING_IDLE;
			s2Msg.opcode <= RING_IDLE;
		end
	end

	assign readIndex = s1Index;
	assign flushSeen = isFlushMsg(s1Msg);

	always_comb
	begin
		reqTag = s2Msg.addr[`L2_ADDR_BITS-1:4];
		isLoad = (s2Msg.opcode == RING_LDX);
		isStore = (s2Msg.opcode == RING_STX);
		isRamReq = (isLoad || isStore) && isRamAddr(s2Msg.addr);
		// generation 0 and stale stamps both count as absent
		tagHit = (curGen != '0) && (readLine.gen == curGen) && (readLine.tag == reqTag);
		hit = tagHit || (isStore && !readLine.dirty);
		// line written at our read edge, readLine is stale
		skip = prevWrEn && (prevWrIndex == s2Index);
		// stores keep off a line that is being filled
		if (isStore && (fillWrite.en || (!missReady && (pendIndex == s2Index))))
		begin
			skip = 1'b1;
		end

		served = s2Msg;
		if (isLoad)
		begin
			served.opcode = RING_OKLD;
			served.data = readLine.tile;
		end
		else
		begin
			served.opcode = RING_OKST;
		end

		storeWrite.en = isRamReq && isStore && hit && !skip;
		storeWrite.index = s2Index;
		storeWrite.line = '{tag: reqTag, dirty: 1'b1, gen: curGen, tile: s2Msg.data};

		missValid = isRamReq && !hit && !skip;
		missReq = '{index: s2Index, tag: reqTag, victim: readLine};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringOut <= '0;
			prevWrEn <= 1'b0;
		end
		else
		begin
			ringOut <= (isRamReq && hit && !skip) ? served : s2Msg;
			prevWrEn <= storeWrite.en || fillWrite.en;
		end
	end

	always_ff @(posedge clock)
	begin
		prevWrIndex <= fillWrite.en ? fillWrite.index : storeWrite.index;
		if (missValid && missReady)
		begin
			pendIndex <= s2Index;
		end
	end

endmodule

//--- hw/l2TileCache.sv
/*
 * L2 tile cache top: direct-mapped, write-back, on the slotted ring.
 * Ring messages leave three cycles after they enter; misses fill over DDR.
 */
`include "l2Cache_config.svh"

module l2TileCache (
	input  logic clock,
	input  logic reset,
	input  l2CachePkg::ringMsg_t ringIn,
	output l2CachePkg::ringMsg_t ringOut,
	output l2CachePkg::ddrReq_t ddrReq,
	input  l2CachePkg::ddrRsp_t ddrRsp
);
	import l2CachePkg::*;

	logic [`L2_INDEX_BITS-1:0] readIndex;
	logic [`L2_GEN_BITS-1:0] curGen;
	lineInfo_t readLine;
	lineWrite_t storeWrite;
	lineWrite_t fillWrite;
	missReq_t missReq;
	logic missValid;
	logic missReady;
	logic flushSeen;

	l2RingPipe pipe0 (
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.ringOut(ringOut),
		.readIndex(readIndex),
		.readLine(readLine),
		.curGen(curGen),
		.storeWrite(storeWrite),
		.fillWrite(fillWrite),
		.missValid(missValid),
		.missReady(missReady),
		.missReq(missReq),
		.flushSeen(flushSeen)
	);

	l2TagStore tagStore0 (
		.clock(clock),
		.readIndex(readIndex),
		.readLine(readLine),
		.storeWrite(storeWrite),
		.fillWrite(fillWrite)
	);

	l2FlushRover rover0 (
		.clock(clock),
		.reset(reset),
		.flushSeen(flushSeen),
		.curGen(curGen)
	);

	l2MissFsm missFsm0 (
		.clock(clock),
		.reset(reset),
		.missValid(missValid),
		.missReady(missReady),
		.missReq(missReq),
		.curGen(curGen),
		.fillWrite(fillWrite),
		.ddrReq(ddrReq),
		.ddrRsp(ddrRsp)
	);

endmodule

//--- verif/l2TileCache_chk.sv
/*
 * Assertions on the miss engine, bound into every l2MissFsm instance.
 * Covers the DDR hold rule, the miss handoff and the fill write timing.
 */
module l2TileCacheChk (
	input  logic clock,
	input  logic reset,
	input  logic missValid,
	input  logic missReady,
	input  l2CachePkg::lineWrite_t fillWrite,
	input  l2CachePkg::ddrReq_t ddrReq,
	input  l2CachePkg::ddrRsp_t ddrRsp
);
	import l2CachePkg::*;

	// request may not move while DDR holds it
	holdStable: assert property (@(posedge clock) disable iff (reset)
		(ddrRsp.ok == OK_HOLD) |=> $stable(ddrReq))
		else $error("ddrReq changed while DDR answered HOLD");

	// an accepted miss takes the engine out of IDLE
	acceptDropsReady: assert property (@(posedge clock) disable iff (reset)
		(missValid && missReady) |=> !missReady)
		else $error("missReady still high after a miss was accepted");

	// IDLE is only reached again through the fill
	readyAfterFill: assert property (@(posedge clock) disable iff (reset)
		$rose(missReady) |-> $past(fillWrite.en))
		else $error("missReady rose without a fill");

	// fill lands one cycle after the tile read is acknowledged
	fillAfterReadOk: assert property (@(posedge clock) disable iff (reset)
		fillWrite.en |-> $past((ddrReq.opcode == DDR_RD_TILE) && (ddrRsp.ok == OK_OK)))
		else $error("fill write without an acknowledged tile read");

endmodule

bind l2MissFsm l2TileCacheChk chk0 (
	.clock(clock),
	.reset(reset),
	.missValid(missValid),
	.missReady(missReady),
	.fillWrite(fillWrite),
	.ddrReq(ddrReq),
	.ddrRsp(ddrRsp)
);

//--- verif/l2TileCacheTb.sv
/*
 * Directed testbench for the L2 tile cache. Drives the ring one slot per
 * cycle, models DDR with random hold cycles and checks each ring response.
 */
`include "l2Cache_config.svh"

module l2TileCacheTb;
	import l2CachePkg::*;

	localparam ringMsg_t idleMsg = '0;
	localparam int retryLimit = 100;
	// A and B share index 4, C and D share index 8
	localparam logic [`L2_ADDR_BITS-1:0] addrA = 32'h0100_0040;
	localparam logic [`L2_ADDR_BITS-1:0] addrB = 32'h0200_0040;
	localparam logic [`L2_ADDR_BITS-1:0] addrC = 32'h0100_0080;
	localparam logic [`L2_ADDR_BITS-1:0] addrD = 32'h0200_0080;
	localparam logic [`L2_ADDR_BITS-1:0] addrE = 32'h0300_0100;
	localparam logic [`L2_ADDR_BITS-1:0] addrF = 32'h0300_0200;
	localparam logic [`L2_ADDR_BITS-1:0] flushAddr = 32'hF000_000E;
	localparam logic [`L2_TILE_BITS-1:0] dataA = 128'h0A0A_1111_2222_3333_4444_5555_6666_7777;
	localparam logic [`L2_TILE_BITS-1:0] dataC = 128'h0C0C_8888_9999_AAAA_BBBB_CCCC_DDDD_EEEE;

	logic clock;
	logic reset;
	ringMsg_t ringIn;
	ringMsg_t ringOut;
	ddrReq_t ddrReq;
	ddrRsp_t ddrRsp = '{ok: OK_READY, data: '0};

	// DDR model state
	logic [`L2_TILE_BITS-1:0] memTiles [logic [`L2_TAG_BITS-1:0]];
	logic [31:0] salt [4];
	logic ddrBusy;
	int holdLeft;
	int holdMin;
	int holdMax;
	int rdCount;
	int wrCount;
	ddrOp_t opLog[$];
	logic [`L2_ADDR_BITS-1:0] lastWrAddr;
	logic [`L2_TILE_BITS-1:0] lastWrData;

	logic [15:0] seqNo;
	ringMsg_t sendQ[$];
	ringMsg_t expQ[$];

	l2TileCache dut0 (
		.clock(clock),
		.reset(reset),
		.ringIn(ringIn),
		.ringOut(ringOut),
		.ddrReq(ddrReq),
		.ddrRsp(ddrRsp)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#4 clock = ~clock;
		end
	end

	// unwritten tiles are a salted function of the tile address
	function automatic logic [`L2_TILE_BITS-1:0] modelTile(input logic [`L2_TAG_BITS-1:0] tag);
		if (memTiles.exists(tag))
		begin
			return memTiles[tag];
		end
		return {salt[0] ^ {4'h0, tag}, salt[1] ^ {tag, 4'h5},
			salt[2] + {4'h0, tag}, salt[3] ^ ~{tag, 4'hA}};
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			ddrBusy = 1'b0;
			ddrRsp <= '{ok: OK_READY, data: '0};
		end
		else if (ddrReq.opcode == DDR_READY)
		begin
			ddrBusy = 1'b0;
			ddrRsp.ok <= OK_READY;
		end
		else if (!ddrBusy)
		begin
			// new request, pick how long to hold it
			ddrBusy = 1'b1;
			holdLeft = holdMin + int'($urandom_range(holdMax - holdMin));
			ddrRsp.ok <= OK_HOLD;
		end
		else if (holdLeft > 0)
		begin
			holdLeft = holdLeft - 1;
		end
		else if (ddrRsp.ok == OK_HOLD)
		begin
			opLog.push_back(ddrReq.opcode);
			if (ddrReq.opcode == DDR_WR_TILE)
			begin
				memTiles[ddrReq.addr[`L2_ADDR_BITS-1:4]] = ddrReq.data;
				lastWrAddr = ddrReq.addr;
				lastWrData = ddrReq.data;
				wrCount = wrCount + 1;
			end
			else
			begin
				ddrRsp.data <= modelTile(ddrReq.addr[`L2_ADDR_BITS-1:4]);
				rdCount = rdCount + 1;
			end
			ddrRsp.ok <= OK_OK;
		end
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkEq(input string what, input logic [255:0] got, input logic [255:0] exp);
		if (got !== exp)
		begin
			abortRun($sformatf("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp));
		end
	endtask

	function automatic ringMsg_t makeMsg(input ringOp_t op, input logic [31:0] addr,
		input logic [`L2_TILE_BITS-1:0] data);
		ringMsg_t msg;
		seqNo = seqNo + 16'd1;
		msg.seq = seqNo;
		msg.opcode = op;
		msg.addr = addr;
		msg.data = data;
		return msg;
	endfunction

	// a served request keeps seq and address, opcode and data change
	function automatic ringMsg_t servedAs(input ringMsg_t req, input ringOp_t op,
		input logic [`L2_TILE_BITS-1:0] data);
		ringMsg_t rsp;
		rsp = req;
		rsp.opcode = op;
		rsp.data = data;
		return rsp;
	endfunction

	// response shows up one ring latency of edges after the drive edge
	task automatic sendOne(input ringMsg_t msg, output ringMsg_t got);
		@(posedge clock);
		ringIn <= msg;
		@(posedge clock);
		ringIn <= idleMsg;
		repeat (`L2_RING_LAT - 1) @(posedge clock);
		@(negedge clock);
		got = ringOut;
	endtask

	task automatic queueMsg(input ringMsg_t msg, input ringMsg_t exp);
		sendQ.push_back(msg);
		expQ.push_back(exp);
	endtask

	// back to back slots, each response checked in its own cycle
	task automatic streamMsgs();
		int count;
		count = sendQ.size();
		for (int j = 0; j < count + `L2_RING_LAT; j++)
		begin
			@(posedge clock);
			if (j < count)
			begin
				ringIn <= sendQ[j];
			end
			else
			begin
				ringIn <= idleMsg;
			end
			@(negedge clock);
			if (j >= `L2_RING_LAT)
			begin
				checkEq($sformatf("stream slot %0d", j - `L2_RING_LAT), ringOut,
					expQ[j - `L2_RING_LAT]);
			end
		end
		sendQ.delete();
		expQ.delete();
	endtask

	task automatic loadRetry(input logic [31:0] addr, output logic [`L2_TILE_BITS-1:0] tile,
		output int tries);
		ringMsg_t msg;
		ringMsg_t got;
		tries = 0;
		got = idleMsg;
		msg = idleMsg;
		while (got.opcode != RING_OKLD)
		begin
			if (tries >= retryLimit)
			begin
				abortRun($sformatf("timeout: load to %h still missing after %0d tries",
					addr, tries));
			end
			msg = makeMsg(RING_LDX, addr, '0);
			sendOne(msg, got);
			tries++;
			if (got.opcode != RING_OKLD)
			begin
				checkEq("missed load passes unchanged", got, msg);
			end
		end
		checkEq("served load keeps seq and address", {got.seq, got.addr}, {msg.seq, msg.addr});
		tile = got.data;
	endtask

	task automatic passThroughMsgs();
		ringMsg_t msg;
		msg = makeMsg(RING_IDLE, 32'h0123_4560, 128'h5A5A);
		queueMsg(msg, msg);
		msg = makeMsg(RING_LDX, 32'hC100_0040, '0);
		queueMsg(msg, msg);
		msg = makeMsg(RING_LDX, 32'h0000_0040, '0);
		queueMsg(msg, msg);
		msg = makeMsg(RING_STX, 32'h4200_0080, 128'h1234);
		queueMsg(msg, msg);
		msg = makeMsg(RING_OKLD, addrA, 128'h9876);
		queueMsg(msg, msg);
		// flush opcode without the flush marker
		msg = makeMsg(RING_FLUSH, 32'hF000_0000, '0);
		queueMsg(msg, msg);
		streamMsgs();
	endtask

	task automatic loadMissRetry();
		logic [`L2_TILE_BITS-1:0] tile;
		int rdBefore;
		int tries;
		rdBefore = rdCount;
		loadRetry(addrA, tile, tries);
		checkEq("first load to A missed", tries > 1, 1);
		checkEq("load A tile", tile, modelTile(addrA[31:4]));
		checkEq("reads for load A", rdCount - rdBefore, 1);
	endtask

	task automatic storeThenLoad();
		ringMsg_t msg;
		ringMsg_t got;
		int rdBefore;
		rdBefore = rdCount;
		msg = makeMsg(RING_STX, addrA, dataA);
		sendOne(msg, got);
		checkEq("store to A", got, servedAs(msg, RING_OKST, dataA));
		msg = makeMsg(RING_LDX, addrA, '0);
		sendOne(msg, got);
		checkEq("load after store to A", got, servedAs(msg, RING_OKLD, dataA));
		checkEq("reads on hit", rdCount - rdBefore, 0);
	endtask

	task automatic dirtyEviction();
		logic [`L2_TILE_BITS-1:0] tile;
		int rdBefore;
		int wrBefore;
		int tries;
		rdBefore = rdCount;
		wrBefore = wrCount;
		loadRetry(addrB, tile, tries);
		checkEq("first load to B missed", tries > 1, 1);
		checkEq("load B tile", tile, modelTile(addrB[31:4]));
		checkEq("victim writes", wrCount - wrBefore, 1);
		checkEq("victim address", lastWrAddr, addrA);
		checkEq("victim data", lastWrData, dataA);
		checkEq("write before read", {opLog[$-1], opLog[$]}, {DDR_WR_TILE, DDR_RD_TILE});
		checkEq("reads for load B", rdCount - rdBefore, 1);
	endtask

	task automatic flushAndRefill();
		ringMsg_t msg;
		ringMsg_t got;
		logic [`L2_TILE_BITS-1:0] tile;
		int rdBefore;
		int wrBefore;
		int tries;
		msg = makeMsg(RING_STX, addrC, dataC);
		sendOne(msg, got);
		checkEq("store to C", got, servedAs(msg, RING_OKST, dataC));
		msg = makeMsg(RING_FLUSH, flushAddr, '0);
		sendOne(msg, got);
		checkEq("flush passes", got, msg);
		rdBefore = rdCount;
		wrBefore = wrCount;
		loadRetry(addrB, tile, tries);
		checkEq("load B missed after flush", tries > 1, 1);
		checkEq("load B tile after flush", tile, modelTile(addrB[31:4]));
		checkEq("reads for B after flush", rdCount - rdBefore, 1);
		checkEq("clean stale victim not written", wrCount - wrBefore, 0);
		// stale but dirty C goes back to DDR
		loadRetry(addrD, tile, tries);
		checkEq("load D tile", tile, modelTile(addrD[31:4]));
		checkEq("stale victim writes", wrCount - wrBefore, 1);
		checkEq("stale victim address", lastWrAddr, addrC);
		checkEq("stale victim data", lastWrData, dataC);
	endtask

	task automatic holdBackPressure();
		ringMsg_t msg;
		ringMsg_t got;
		logic [`L2_TILE_BITS-1:0] tile;
		int rdBefore;
		int tries;
		holdMin = 30;
		holdMax = 60;
		rdBefore = rdCount;
		msg = makeMsg(RING_LDX, addrE, '0);
		sendOne(msg, got);
		checkEq("load E misses", got, msg);
		msg = makeMsg(RING_LDX, addrB, '0);
		queueMsg(msg, servedAs(msg, RING_OKLD, modelTile(addrB[31:4])));
		msg = makeMsg(RING_LDX, addrF, '0);
		queueMsg(msg, msg);
		msg = makeMsg(RING_LDX, addrD, '0);
		queueMsg(msg, servedAs(msg, RING_OKLD, modelTile(addrD[31:4])));
		msg = makeMsg(RING_IDLE, 32'h0, 128'h77);
		queueMsg(msg, msg);
		msg = makeMsg(RING_LDX, addrB, '0);
		queueMsg(msg, servedAs(msg, RING_OKLD, modelTile(addrB[31:4])));
		streamMsgs();
		checkEq("fill still pending", rdCount - rdBefore, 0);
		loadRetry(addrE, tile, tries);
		checkEq("load E tile", tile, modelTile(addrE[31:4]));
		loadRetry(addrF, tile, tries);
		checkEq("load F tile", tile, modelTile(addrF[31:4]));
		checkEq("reads under hold", rdCount - rdBefore, 2);
		holdMin = 0;
		holdMax = 8;
	endtask

	initial
	begin
		repeat (100000) @(posedge clock);
		abortRun("global timeout: the test sequence never finished");
	end

	initial
	begin
		void'($urandom(32'he3b4_2329));
		for (int i = 0; i < 4; i++)
		begin
			salt[i] = $urandom();
		end
		holdMin = 0;
		holdMax = 8;
		holdLeft = 0;
		rdCount = 0;
		wrCount = 0;
		seqNo = 16'd0;
		ringIn = idleMsg;
		reset = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		// let the rover leave generation 0
		repeat (4) @(posedge clock);

		passThroughMsgs();
		loadMissRetry();
		storeThenLoad();
		dirtyEviction();
		flushAndRefill();
		holdBackPressure();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- l2TileCache.f
+incdir+hw
hw/l2CachePkg.sv
hw/l2FlushRover.sv
hw/l2TagStore.sv
hw/l2MissFsm.sv
hw/l2RingPipe.sv
hw/l2TileCache.sv
verif/l2TileCache_chk.sv
verif/l2TileCacheTb.sv

//--- Makefile
# Verilator build and run for the L2 tile cache testbench.
# Any variable can be overridden on the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP ?= l2TileCacheTb
FILELIST ?= l2TileCache.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --x-initial 0 -Wno-fatal

SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# exit status of the simulation is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
